/* tlb_check_defs.svh */
// TLB checker widths, descriptor field positions and the user mode value.
`ifndef TLB_CHECK_DEFS_SVH
`define TLB_CHECK_DEFS_SVH

// ======================================================================
// Widths
// ======================================================================
`define TLB_VA_W                32              // Virtual and physical address.
`define TLB_DAC_W               32              // Sixteen 2-bit domain fields.
`define TLB_FSR_W               8               // Domain nibble and fault code.
`define TLB_MODE_W              5               // Processor mode field.
`define TLB_MODE_USR            5'h10           // User mode.

// The section fields take 34 bits in total.
`define TLB_SEC_ENTRY_W         34              // Section entry.
`define TLB_SPG_ENTRY_W         56              // Small page entry.

// ======================================================================
// Section entry fields
// ======================================================================
`define TLB_SEC_TAG             33:22           // Matched against VA[31:20].
`define TLB_SEC_BASE            21:10           // Physical section base.
`define TLB_SEC_AP              9:8             // Access permission.
`define TLB_SEC_DOM             7:4             // Domain number.
`define TLB_SEC_C               3               // Cacheable.
`define TLB_SEC_B               2               // Bufferable.
`define TLB_SEC_TYPE            1:0             // Descriptor type.

// ======================================================================
// Small page entry fields
// ======================================================================
`define TLB_SPG_TAG             55:36           // Matched against VA[31:12].
`define TLB_SPG_BASE            35:16           // Physical page base.
`define TLB_SPG_AP              15:8            // Four AP subfields.
`define TLB_SPG_DOM             7:4             // Domain number.
`define TLB_SPG_C               3               // Cacheable.
`define TLB_SPG_B               2               // Bufferable.
`define TLB_SPG_TYPE            1:0             // Descriptor type.

// Virtual address slices.
`define TLB_VA_SEC_TAG          31:20           // Section index.
`define TLB_VA_SEC_OFS          19:0            // Offset in section.
`define TLB_VA_SPG_TAG          31:12           // Small page index.
`define TLB_VA_SPG_OFS          11:0            // Offset in page.
`define TLB_VA_SPG_AP_SEL       11:10           // Picks one AP subfield.

`endif

/* tlb_check_pkg.sv */
// Shared state, hit kind, domain mode and fault code types for the TLB checker.
`default_nettype none

package tlb_check_pkg;

        // Handshake sequencer states.
        typedef enum logic [1:0]
        {
                ST_IDLE = 2'd0,                 // Waiting for a request.
                ST_ACK  = 2'd1                  // Result held, ack high.
        } check_state_e;

        // Which TLB supplied the entry.
        typedef enum logic [1:0]
        {
                HIT_NONE    = 2'd0,             // Miss in both.
                HIT_SECTION = 2'd1,             // Section TLB.
                HIT_SPAGE   = 2'd2              // Small page TLB.
        } hit_kind_e;

        // One 2-bit field of the DAC register.
        typedef enum logic [1:0]
        {
                DAC_NO_ACCESS = 2'd0,           // Any access faults.
                DAC_CLIENT    = 2'd1,           // AP bits are checked.
                DAC_RESERVED  = 2'd2,           // Treated as no access.
                DAC_MANAGER   = 2'd3            // AP bits ignored.
        } dac_mode_e;

        // ======================================================================
        // Fault codes for the lower nibble of the FSR
        // ======================================================================
        typedef enum logic [3:0]
        {
                FSR_SEC_TRANS    = 4'h5,        // Section translation.
                FSR_PAGE_TRANS   = 4'h7,        // Page translation.
                FSR_SEC_DOMAIN   = 4'h9,        // Section domain.
                FSR_PAGE_DOMAIN  = 4'hB,        // Page domain.
                FSR_L1_EXT_ABORT = 4'hC,        // External abort on L1.
                FSR_SEC_PERM     = 4'hD,        // Section permission.
                FSR_L2_EXT_ABORT = 4'hE,        // External abort on L2.
                FSR_PAGE_PERM    = 4'hF         // Page permission.
        } fsr_code_e;

endpackage : tlb_check_pkg

`default_nettype wire

/* tlb_match_decode.sv */
// Tag compare and field extraction for one section and one small page entry.
`timescale 1ns/1ps
`default_nettype none

`include "tlb_check_defs.svh"

module tlb_match_decode
(
        input  logic [`TLB_VA_W-1:0]            i_va,           // Virtual address.
        input  logic [`TLB_SEC_ENTRY_W-1:0]     i_sec_entry,    // Section TLB entry.
        input  logic                            i_sec_valid,    // Section entry valid.
        input  logic [`TLB_SPG_ENTRY_W-1:0]     i_spg_entry,    // Small page TLB entry.
        input  logic                            i_spg_valid,    // Small page entry valid.

        output tlb_check_pkg::hit_kind_e        o_hit_kind,     // Which entry hit.
        output logic [`TLB_VA_W-1:0]            o_phy_addr,     // Formed physical address.
        output logic                            o_cacheable,    // C bit of the hit.
        output logic [1:0]                      o_ap,           // Selected AP field.
        output logic [3:0]                      o_domain,       // Entry domain.
        output logic [1:0]                      o_desc_type     // Descriptor type.
);

        import tlb_check_pkg::*;

        logic                   sec_match;      // Section tag hit.
        logic                   spg_match;      // Small page tag hit.
        logic [3:0][1:0]        spg_ap;         // Small page AP subfields.

        assign sec_match = i_sec_valid &&
                           (i_sec_entry[`TLB_SEC_TAG] == i_va[`TLB_VA_SEC_TAG]);
        assign spg_match = i_spg_valid &&
                           (i_spg_entry[`TLB_SPG_TAG] == i_va[`TLB_VA_SPG_TAG]);

        assign spg_ap = i_spg_entry[`TLB_SPG_AP];       // One subfield per 1 KB.

        // ======================================================================
        // Entry select
        // ======================================================================
        always_comb
        begin
                o_hit_kind  = HIT_NONE;                 // Miss by default.
                o_phy_addr  = i_va;                     // Flat map.
                o_cacheable = 1'b0;
                o_ap        = 2'b00;
                o_domain    = 4'd0;
                o_desc_type = 2'b00;

                if (sec_match)
                begin
                        o_hit_kind  = HIT_SECTION;
                        o_phy_addr  = {i_sec_entry[`TLB_SEC_BASE], i_va[`TLB_VA_SEC_OFS]};
                        o_cacheable = i_sec_entry[`TLB_SEC_C];
                        o_ap        = i_sec_entry[`TLB_SEC_AP];
                        o_domain    = i_sec_entry[`TLB_SEC_DOM];
                        o_desc_type = i_sec_entry[`TLB_SEC_TYPE];
                end
                else if (spg_match)
                begin
                        o_hit_kind  = HIT_SPAGE;
                        o_phy_addr  = {i_spg_entry[`TLB_SPG_BASE], i_va[`TLB_VA_SPG_OFS]};
                        o_cacheable = i_spg_entry[`TLB_SPG_C];
                        o_ap        = spg_ap[i_va[`TLB_VA_SPG_AP_SEL]];     // Subpage AP.
                        o_domain    = i_spg_entry[`TLB_SPG_DOM];
                        o_desc_type = i_spg_entry[`TLB_SPG_TYPE];
                end
        end

        // The section and small page TLBs never map the same address.
        always_comb
        begin
                a_single_hit : assert final (!(sec_match && spg_match));
        end

endmodule : tlb_match_decode

`default_nettype wire

/* access_perm_check.sv */
// Descriptor type, domain and AP/SR permission checks giving the fault status.
`timescale 1ns/1ps
`default_nettype none

`include "tlb_check_defs.svh"

module access_perm_check
(
        input  tlb_check_pkg::hit_kind_e        i_hit_kind,     // Which entry hit.
        input  logic [1:0]                      i_ap,           // Selected AP field.
        input  logic [3:0]                      i_domain,       // Entry domain.
        input  logic [1:0]                      i_desc_type,    // Descriptor type.
        input  logic [`TLB_MODE_W-1:0]          i_cpsr_mode,    // Processor mode.
        input  logic                            i_rd,           // Read access.
        input  logic                            i_wr,           // Write access.
        input  logic [1:0]                      i_sr,           // S and R bits.
        input  logic [`TLB_DAC_W-1:0]           i_dac_reg,      // Domain access control.

        output logic [`TLB_FSR_W-1:0]           o_fsr           // Zero means no fault.
);

        import tlb_check_pkg::*;

        logic           user;           // User mode access.
        logic           is_sec;         // Section codes apply.
        logic           perm_ok;        // Permission table result.
        logic           fault;          // Any fault raised.
        dac_mode_e      dac_mode;       // Decoded domain field.
        fsr_code_e      code;           // Selected fault code.

        assign user     = (i_cpsr_mode == `TLB_MODE_USR);
        assign is_sec   = (i_hit_kind == HIT_SECTION);
        assign dac_mode = dac_mode_e'(i_dac_reg[{i_domain, 1'b0} +: 2]);  // Two bits per domain.

        // ======================================================================
        // AP/SR permission table
        // ======================================================================
        always_comb
        begin
                case (i_ap)
                2'b00:
                begin
                        case (i_sr)
                        2'b10:   perm_ok = !user && i_rd && !i_wr;      // Kernel read only.
                        2'b01:   perm_ok = i_rd && !i_wr;               // Anyone reads.
                        default: perm_ok = 1'b0;                        // No access.
                        endcase
                end
                2'b01:   perm_ok = !user;                               // Kernel only.
                2'b10:   perm_ok = !user || (i_rd && !i_wr);            // User read only.
                default: perm_ok = 1'b1;                                // Full access.
                endcase
        end

        // ======================================================================
        // Fault priority
        // ======================================================================
        always_comb
        begin
                fault = 1'b0;
                code  = is_sec ? FSR_SEC_TRANS : FSR_PAGE_TRANS;

                if (i_desc_type == 2'b00)
                begin
                        fault = 1'b1;                                   // Translation fault.
                end
                else if (i_desc_type == 2'b11)
                begin
                        fault = 1'b1;                                   // External abort.
                        code  = is_sec ? FSR_L1_EXT_ABORT : FSR_L2_EXT_ABORT;
                end
                else
                begin
                        case (dac_mode)
                        DAC_MANAGER: fault = 1'b0;                      // No checks.
                        DAC_CLIENT:
                        begin
                                fault = !perm_ok;
                                code  = is_sec ? FSR_SEC_PERM : FSR_PAGE_PERM;
                        end
                        default:
                        begin
                                fault = 1'b1;                           // No access or reserved.
                                code  = is_sec ? FSR_SEC_DOMAIN : FSR_PAGE_DOMAIN;
                        end
                        endcase
                end

                // Nothing to report on a miss.
                o_fsr = (fault && (i_hit_kind != HIT_NONE)) ? {i_domain, code} : '0;
        end

endmodule : access_perm_check

`default_nettype wire

/* check_sequencer.sv */
// Four-phase req/ack sequencer that registers the TLB check result.
`timescale 1ns/1ps
`default_nettype none

`include "tlb_check_defs.svh"

module check_sequencer
(
        input  logic                            i_clk,          // Clock.
        input  logic                            i_rst_n,        // Async reset, active low.
        input  logic                            i_req,          // Request, four-phase.
        input  logic                            i_mmu_en,       // MMU enable.
        input  logic                            i_rd,           // Read access.
        input  logic                            i_wr,           // Write access.
        input  logic [`TLB_VA_W-1:0]            i_va,           // Virtual address.
        input  tlb_check_pkg::hit_kind_e        i_hit_kind,     // Decoded hit kind.
        input  logic [`TLB_FSR_W-1:0]           i_fsr,          // Permission result.
        input  logic [`TLB_VA_W-1:0]            i_phy_addr,     // Decoded address.
        input  logic                            i_cacheable,    // Decoded C bit.

        output logic                            o_ack,          // Result valid.
        output logic                            o_walk,         // Page walk needed.
        output logic [`TLB_FSR_W-1:0]           o_fsr,          // Fault status.
        output logic [`TLB_VA_W-1:0]            o_far,          // Fault address.
        output logic [`TLB_VA_W-1:0]            o_phy_addr,     // Physical address.
        output logic                            o_cacheable     // Cacheable access.
);

        import tlb_check_pkg::*;

        check_state_e   state;          // Current state.
        check_state_e   state_nxt;      // Next state.
        logic           accept;         // Take a new request.
        logic           check_on;       // Translation applies.
        logic           use_tlb;        // Check applies and hit.

        assign accept   = (state == ST_IDLE) && i_req;
        assign check_on = i_mmu_en && (i_rd || i_wr);
        assign use_tlb  = check_on && (i_hit_kind != HIT_NONE);
        assign o_ack    = (state == ST_ACK);

        always_comb
        begin
                case (state)
                ST_IDLE: state_nxt = i_req ? ST_ACK : ST_IDLE;
                ST_ACK:  state_nxt = i_req ? ST_ACK : ST_IDLE;  // Hold until req drops.
                default: state_nxt = ST_IDLE;
                endcase
        end

        // ======================================================================
        // Control and status registers
        // ======================================================================
        always_ff @(posedge i_clk or negedge i_rst_n)
        begin
                if (!i_rst_n)
                begin
                        state       <= ST_IDLE;
                        o_walk      <= 1'b0;
                        o_fsr       <= '0;
                        o_cacheable <= 1'b0;
                end
                else
                begin
                        state <= state_nxt;
                        if (accept)
                        begin
                                o_walk      <= check_on && (i_hit_kind == HIT_NONE);
                                o_fsr       <= use_tlb ? i_fsr : '0;
                                o_cacheable <= use_tlb && i_cacheable;
                        end
                end
        end

        // Address results.
        always_ff @(posedge i_clk)
        begin
                if (accept)
                begin
                        o_far      <= i_va;                             // Always the request.
                        o_phy_addr <= use_tlb ? i_phy_addr : i_va;
                end
        end

        // Request inputs stay put while the handshake is open.
        a_req_stable : assert property (@(posedge i_clk) disable iff (!i_rst_n)
                (o_ack && i_req) |-> $stable({i_va, i_mmu_en, i_rd, i_wr}));

        // The permission check reports nothing on a miss.
        a_miss_no_fault : assert property (@(posedge i_clk) disable iff (!i_rst_n)
                (i_hit_kind == HIT_NONE) |-> (i_fsr == '0));

endmodule : check_sequencer

`default_nettype wire

/* tlb_check_top.sv */
// TLB access checker top level joining decode, permission check and sequencer.
`timescale 1ns/1ps
`default_nettype none

`include "tlb_check_defs.svh"

module tlb_check_top
(
        input  logic                            i_clk,          // Clock.
        input  logic                            i_rst_n,        // Async reset, active low.
        input  logic                            i_req,          // Request.
        input  logic                            i_mmu_en,       // MMU enable.
        input  logic [`TLB_VA_W-1:0]            i_va,           // Virtual address.
        input  logic                            i_rd,           // Read access.
        input  logic                            i_wr,           // Write access.
        input  logic [`TLB_MODE_W-1:0]          i_cpsr_mode,    // Processor mode.
        input  logic [1:0]                      i_sr,           // S and R bits.
        input  logic [`TLB_DAC_W-1:0]           i_dac_reg,      // Domain access control.
        input  logic [`TLB_SEC_ENTRY_W-1:0]     i_sec_entry,    // Section TLB entry.
        input  logic                            i_sec_valid,    // Section entry valid.
        input  logic [`TLB_SPG_ENTRY_W-1:0]     i_spg_entry,    // Small page TLB entry.
        input  logic                            i_spg_valid,    // Small page entry valid.

        output logic                            o_ack,          // Result valid.
        output logic                            o_walk,         // Page walk needed.
        output logic [`TLB_FSR_W-1:0]           o_fsr,          // Fault status.
        output logic [`TLB_VA_W-1:0]            o_far,          // Fault address.
        output logic [`TLB_VA_W-1:0]            o_phy_addr,     // Physical address.
        output logic                            o_cacheable     // Cacheable access.
);

        import tlb_check_pkg::*;

        hit_kind_e              hit_kind;       // Decoded hit.
        logic [`TLB_VA_W-1:0]   dec_phy_addr;   // Decoded address.
        logic                   dec_cacheable;  // Decoded C bit.
        logic [1:0]             ap;             // Selected AP.
        logic [3:0]             domain;         // Entry domain.
        logic [1:0]             desc_type;      // Descriptor type.
        logic [`TLB_FSR_W-1:0]  perm_fsr;       // Permission result.

        tlb_match_decode tlb_match_decode_inst
        (
                .i_va           (i_va),
                .i_sec_entry    (i_sec_entry),
                .i_sec_valid    (i_sec_valid),
                .i_spg_entry    (i_spg_entry),
                .i_spg_valid    (i_spg_valid),
                .o_hit_kind     (hit_kind),
                .o_phy_addr     (dec_phy_addr),
                .o_cacheable    (dec_cacheable),
                .o_ap           (ap),
                .o_domain       (domain),
                .o_desc_type    (desc_type)
        );

        access_perm_check access_perm_check_inst
        (
                .i_hit_kind     (hit_kind),
                .i_ap           (ap),
                .i_domain       (domain),
                .i_desc_type    (desc_type),
                .i_cpsr_mode    (i_cpsr_mode),
                .i_rd           (i_rd),
                .i_wr           (i_wr),
                .i_sr           (i_sr),
                .i_dac_reg      (i_dac_reg),
                .o_fsr          (perm_fsr)
        );

        check_sequencer check_sequencer_inst
        (
                .i_clk          (i_clk),
                .i_rst_n        (i_rst_n),
                .i_req          (i_req),
                .i_mmu_en       (i_mmu_en),
                .i_rd           (i_rd),
                .i_wr           (i_wr),
                .i_va           (i_va),
                .i_hit_kind     (hit_kind),
                .i_fsr          (perm_fsr),
                .i_phy_addr     (dec_phy_addr),
                .i_cacheable    (dec_cacheable),
                .o_ack          (o_ack),
                .o_walk         (o_walk),
                .o_fsr          (o_fsr),
                .o_far          (o_far),
                .o_phy_addr     (o_phy_addr),
                .o_cacheable    (o_cacheable)
        );

endmodule : tlb_check_top

`default_nettype wire

/* tb_tlb_check.sv */
// Random-stimulus testbench for the TLB access checker against a reference model.
`timescale 1ns/1ps
`default_nettype none

`include "tlb_check_defs.svh"

module tb_tlb_check;

        localparam int NUM_REQ  = 500;                  // Requests in the run.
        localparam int WAIT_MAX = 16;                   // Cycles allowed per wait.

        logic                           i_clk = 1'b0;
        logic                           i_rst_n;
        logic                           i_req;
        logic                           i_mmu_en;
        logic [`TLB_VA_W-1:0]           i_va;
        logic                           i_rd;
        logic                           i_wr;
        logic [`TLB_MODE_W-1:0]         i_cpsr_mode;
        logic [1:0]                     i_sr;
        logic [`TLB_DAC_W-1:0]          i_dac_reg;
        logic [`TLB_SEC_ENTRY_W-1:0]    i_sec_entry;
        logic                           i_sec_valid;
        logic [`TLB_SPG_ENTRY_W-1:0]    i_spg_entry;
        logic                           i_spg_valid;
        logic                           o_ack;
        logic                           o_walk;
        logic [`TLB_FSR_W-1:0]          o_fsr;
        logic [`TLB_VA_W-1:0]           o_far;
        logic [`TLB_VA_W-1:0]           o_phy_addr;
        logic                           o_cacheable;

        logic [`TLB_FSR_W-1:0]          exp_fsr;        // Model fault status.
        logic                           exp_walk;       // Model walk request.
        logic [`TLB_VA_W-1:0]           exp_phy;        // Model physical address.
        logic [`TLB_VA_W-1:0]           exp_far;        // Request address.
        logic                           exp_c;          // Model cacheable.

        tlb_check_top tlb_check_top_inst (.*);

        always #10 i_clk = ~i_clk;                      // 20 ns period.

        // ======================================================================
        // Reference model
        // ======================================================================
        function automatic logic perm_allowed(input logic [1:0] ap, input logic [1:0] sr,
                                              input logic user, input logic wr);
                case (ap)
                2'b00:   return (sr == 2'b10) ? (!user && !wr) : ((sr == 2'b01) && !wr);
                2'b01:   return !user;                          // Kernel only.
                2'b10:   return !user || !wr;                   // User may only read.
                default: return 1'b1;
                endcase
        endfunction

        function automatic logic [7:0] model_fsr(input logic is_sec, input logic [1:0] ap,
                        input logic [3:0] dom, input logic [1:0] dtype, input logic [31:0] dac,
                        input logic user, input logic wr, input logic [1:0] sr);
                logic [31:0]    field;
                logic [3:0]     code;

                field = dac >> (2 * int'(dom));                 // Domain field to bits 1:0.
                if (dtype == 2'b00)
                        code = is_sec ? 4'h5 : 4'h7;            // Translation.
                else if (dtype == 2'b11)
                        code = is_sec ? 4'hC : 4'hE;            // External abort.
                else if (field[1:0] == 2'b11)
                        return 8'h00;                           // Manager.
                else if (field[1:0] == 2'b01)
                begin
                        if (perm_allowed(ap, sr, user, wr))
                                return 8'h00;
                        code = is_sec ? 4'hD : 4'hF;            // Permission.
                end
                else
                        code = is_sec ? 4'h9 : 4'hB;            // Domain.
                return {dom, code};
        endfunction

        // ======================================================================
        // Checks
        // ======================================================================
        task automatic stop_on_error(input string msg);
                $display("%s", msg);
                $display("Verification failed");
                $fatal(1);
        endtask

        task automatic check_val(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
                assert (actual === expected)
                else stop_on_error($sformatf("CHECK FAILED: %s expected 0x%0h actual 0x%0h",
                                             name, expected, actual));
        endtask

        task automatic check_results();
                check_val("o_fsr", 64'(exp_fsr), 64'(o_fsr));
                check_val("o_walk", 64'(exp_walk), 64'(o_walk));
                check_val("o_phy_addr", 64'(exp_phy), 64'(o_phy_addr));
                check_val("o_far", 64'(exp_far), 64'(o_far));
                check_val("o_cacheable", 64'(exp_c), 64'(o_cacheable));
        endtask

        // Ack must follow req at the next edge.
        task automatic wait_ack(input logic level);
                int cycles;

                cycles = 0;
                do
                begin
                        @(negedge i_clk);
                        cycles++;
                end
                while ((o_ack !== level) && (cycles < WAIT_MAX));
                if (o_ack !== level)
                        stop_on_error($sformatf("Timed out waiting for o_ack to become %0d", level));
                assert (cycles == 1)
                else stop_on_error("o_ack did not follow i_req at the next clock edge");
        endtask

        // ======================================================================
        // Stimulus
        // ======================================================================
        task automatic build_request();
                logic [31:0]    r;
                logic [31:0]    ctl;
                logic [31:0]    bases;
                int             kind;           // 0 section hit, 1 small page hit, 2 miss.
                int             sel;
                logic           user;
                logic [3:0]     dom;
                logic [1:0]     dtype;
                logic [1:0]     sec_ap;
                logic [1:0]     ap_sub [4];
                logic [11:0]    m12;
                logic [19:0]    m20;
                logic [11:0]    sec_tag;
                logic [19:0]    spg_tag;

                i_va        = $urandom();
                bases       = $urandom();
                r           = $urandom();
                kind        = int'(r % 3);
                ctl         = $urandom();
                i_mmu_en    = (ctl[3:0] != 4'h0);               // Mostly enabled.
                i_rd        = ctl[4];
                i_wr        = ctl[5];
                i_sr        = ctl[7:6];
                user        = ctl[8];
                i_cpsr_mode = user ? `TLB_MODE_USR : {1'b1, ctl[12:9] | 4'h1};
                dom         = ctl[16:13];
                dtype       = (ctl[19:17] == 3'd0) ? {ctl[20], ctl[20]} : {ctl[21], ~ctl[21]};
                sec_ap      = ctl[23:22];
                for (int i = 0; i < 4; i++)
                        ap_sub[i] = (2'(i) + ctl[25:24]) ^ ctl[27:26];  // All four distinct.

                r   = $urandom();
                m12 = (r[11:0] == 12'h0) ? 12'h1 : r[11:0];     // Nonzero tag flips.
                m20 = (r[31:12] == 20'h0) ? 20'h1 : r[31:12];
                r   = $urandom();
                sel = int'(r % 10);
                i_dac_reg = $urandom();
                i_dac_reg[2 * int'(dom) +: 2] = (sel < 4) ? 2'b01 : (sel < 7) ? 2'b11 :
                                                (sel == 7) ? 2'b00 : 2'b10;

                // A losing entry is either invalid with a matching tag or valid with a wrong one.
                sec_tag     = i_va[`TLB_VA_SEC_TAG];
                spg_tag     = i_va[`TLB_VA_SPG_TAG];
                i_sec_valid = (kind == 0) || !ctl[28];
                i_spg_valid = (kind == 1) || !ctl[29];
                if ((kind != 0) && !ctl[28])
                        sec_tag = sec_tag ^ m12;
                if ((kind != 1) && !ctl[29])
                        spg_tag = spg_tag ^ m20;
                i_sec_entry = {sec_tag, bases[11:0], sec_ap, dom, ctl[30], ctl[31], dtype};
                i_spg_entry = {spg_tag, bases[31:12], ap_sub[3], ap_sub[2], ap_sub[1], ap_sub[0],
                               dom, ctl[30], ctl[31], dtype};

                exp_far  = i_va;
                exp_walk = 1'b0;
                exp_fsr  = 8'h00;
                exp_phy  = i_va;                                // Pass-through default.
                exp_c    = 1'b0;
                if (i_mmu_en && (i_rd || i_wr))
                begin
                        if (kind == 2)
                                exp_walk = 1'b1;
                        else if (kind == 0)
                        begin
                                exp_phy = {bases[11:0], i_va[`TLB_VA_SEC_OFS]};
                                exp_c   = ctl[30];
                                exp_fsr = model_fsr(1'b1, sec_ap, dom, dtype, i_dac_reg,
                                                    user, i_wr, i_sr);
                        end
                        else
                        begin
                                exp_phy = {bases[31:12], i_va[`TLB_VA_SPG_OFS]};
                                exp_c   = ctl[30];
                                exp_fsr = model_fsr(1'b0, ap_sub[i_va[`TLB_VA_SPG_AP_SEL]], dom,
                                                    dtype, i_dac_reg, user, i_wr, i_sr);
                        end
                end
        endtask

        initial
        begin
                int extra;

                void'($urandom(32'h2357_d0bb));                 // Fixed seed.
                i_rst_n     = 1'b0;
                i_req       = 1'b0;
                i_mmu_en    = 1'b0;
                i_va        = '0;
                i_rd        = 1'b0;
                i_wr        = 1'b0;
                i_cpsr_mode = '0;
                i_sr        = 2'b00;
                i_dac_reg   = '0;
                i_sec_entry = '0;
                i_sec_valid = 1'b0;
                i_spg_entry = '0;
                i_spg_valid = 1'b0;
                repeat (5) @(negedge i_clk);
                i_rst_n = 1'b1;
                check_val("o_ack", 64'd0, 64'(o_ack));
                check_val("o_walk", 64'd0, 64'(o_walk));
                check_val("o_fsr", 64'd0, 64'(o_fsr));
                check_val("o_cacheable", 64'd0, 64'(o_cacheable));

                for (int n = 0; n < NUM_REQ; n++)
                begin
                        build_request();
                        i_req = 1'b1;
                        wait_ack(1'b1);
                        check_results();
                        extra = int'($urandom() % 4);
                        repeat (extra)
                        begin
                                @(negedge i_clk);               // Requester holds req.
                                check_val("o_ack", 64'd1, 64'(o_ack));
                                check_results();
                        end
                        i_req       = 1'b0;
                        i_va        = $urandom();               // Results must not follow.
                        i_dac_reg   = $urandom();
                        i_sec_valid = 1'b0;
                        i_spg_valid = 1'b0;
                        wait_ack(1'b0);
                        check_results();
                        extra = int'($urandom() % 3);
                        repeat (extra) @(negedge i_clk);
                end
                $display("Verification passed");
                $finish;
        end

endmodule : tb_tlb_check

`default_nettype wire

/* tlb_check_top.f */
+incdir+.
tlb_check_pkg.sv
tlb_match_decode.sv
access_perm_check.sv
check_sequencer.sv
tlb_check_top.sv
tb_tlb_check.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_tlb_check -f tlb_check_top.f
./obj_dir/Vtb_tlb_check > sim.log 2>&1 || true
cat sim.log
if grep -q "Verification failed" sim.log
then
        exit 1
fi
grep -q "Verification passed" sim.log
